// ==== rtl/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Datapath widths
`define LSU_XLEN        32
`define LSU_OP_W        6
`define LSU_SIZE_W      3

// Operation numbers from the decoder
`define LSU_OP_LB       6'd27
`define LSU_OP_LH       6'd28
`define LSU_OP_LW       6'd29
`define LSU_OP_LBU      6'd30
`define LSU_OP_LHU      6'd31
`define LSU_OP_SB       6'd32
`define LSU_OP_SH       6'd33
`define LSU_OP_SW       6'd34
`define LSU_OP_AMOSWAP  6'd60

// Default data memory shape
`define LSU_MEM_WORDS   256
`define LSU_MEM_WAIT    2

`endif

// ==== rtl/lsu_pkg.sv ====
`default_nettype none
`include "lsu_consts.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0] word_t;

  // Anything outside this list is not a memory operation
  typedef enum logic [`LSU_OP_W-1:0] {
    OP_LB      = `LSU_OP_LB,
    OP_LH      = `LSU_OP_LH,
    OP_LW      = `LSU_OP_LW,
    OP_LBU     = `LSU_OP_LBU,
    OP_LHU     = `LSU_OP_LHU,
    OP_SB      = `LSU_OP_SB,
    OP_SH      = `LSU_OP_SH,
    OP_SW      = `LSU_OP_SW,
    OP_AMOSWAP = `LSU_OP_AMOSWAP
  } lsu_op_e;

  // One-hot access size on the bus
  typedef enum logic [`LSU_SIZE_W-1:0] {
    SIZE_BYTE = 3'b001,
    SIZE_HALF = 3'b010,
    SIZE_WORD = 3'b100
  } access_size_e;

  typedef enum logic {
    PHASE_FETCH   = 1'b0,
    PHASE_EXECUTE = 1'b1
  } phase_e;

endpackage

`default_nettype wire

// ==== rtl/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module data_memory #(
  parameter int MEM_WORDS = `LSU_MEM_WORDS,
  parameter int MEM_WAIT  = `LSU_MEM_WAIT
) (
  input  wire                          i_clk,
  input  wire                          i_reset,
  input  wire                          i_req,
  input  wire lsu_pkg::access_size_e   i_size,
  input  wire lsu_pkg::word_t          i_address,
  input  wire lsu_pkg::word_t          i_wdata,
  input  wire                          i_write,
  output logic                         o_rsp,
  output lsu_pkg::word_t               o_rdata
);

  localparam int LANES  = `LSU_XLEN / 8;
  localparam int LANE_W = $clog2(LANES);
  localparam int IDX_W  = $clog2(MEM_WORDS);
  localparam int CNT_W  = $clog2(MEM_WAIT + 1);

  lsu_pkg::word_t     mem [MEM_WORDS];

  logic [IDX_W-1:0]   idx;
  logic [LANE_W-1:0]  lane;
  logic [LANES-1:0]   byte_en;
  lsu_pkg::word_t     wr_shift;
  lsu_pkg::word_t     rd_shift;
  lsu_pkg::word_t     rd_low;
  logic [CNT_W-1:0]   wait_cnt;

  assign idx  = i_address[IDX_W+LANE_W-1:LANE_W];
  assign lane = i_address[LANE_W-1:0];

  // Little endian, lowest address in the low byte lane
  assign wr_shift = i_wdata << {lane, 3'b000};
  assign rd_shift = mem[idx] >> {lane, 3'b000};

  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_BYTE: begin
        byte_en = LANES'(4'b0001) << lane;
        rd_low  = {{(`LSU_XLEN-8){1'b0}}, rd_shift[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        byte_en = LANES'(4'b0011) << lane;
        rd_low  = {{(`LSU_XLEN-16){1'b0}}, rd_shift[15:0]};
      end
      default: begin
        byte_en = '1;
        rd_low  = rd_shift;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_req) begin
      if (i_write) begin
        for (int k = 0; k < LANES; k++) begin
          if (byte_en[k]) begin
            mem[idx][8*k +: 8] <= wr_shift[8*k +: 8];
          end
        end
      end
      o_rdata <= i_write ? '0 : rd_low;
    end
  end

  // Counts down the fixed wait, response on the last count
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wait_cnt <= '0;
    end else if (i_req) begin
      wait_cnt <= CNT_W'(MEM_WAIT);
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  assign o_rsp = (wait_cnt == CNT_W'(1));

endmodule

`default_nettype wire

// ==== rtl/load_store.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module load_store (
  input  wire                          i_clk,
  input  wire                          i_reset,
  input  wire lsu_pkg::phase_e         i_phase,
  input  wire lsu_pkg::lsu_op_e        i_op,
  input  wire lsu_pkg::word_t          i_rs1,
  input  wire lsu_pkg::word_t          i_rs2,
  input  wire lsu_pkg::word_t          i_ir,
  input  wire lsu_pkg::word_t          i_pc,
  input  wire                          i_start_fetch,
  input  wire                          i_bus_rsp,
  input  wire lsu_pkg::word_t          i_bus_rdata,
  output logic                         o_bus_req,
  output lsu_pkg::access_size_e        o_bus_size,
  output lsu_pkg::word_t               o_bus_address,
  output lsu_pkg::word_t               o_bus_wdata,
  output logic                         o_bus_write,
  output lsu_pkg::word_t               o_ir_value,
  output logic                         o_ir_dv,
  output lsu_pkg::word_t               o_loaded_value,
  output logic                         o_loaded_value_dv,
  output logic                         o_ld_st_finished,
  output logic                         o_amo_finished
);

  typedef enum logic {LS_READY, LS_WAITING} ls_state_e;

  typedef enum logic [2:0] {
    AMO_IDLE,
    AMO_RD_WAIT,
    AMO_WR_ISSUE,
    AMO_WR_WAIT,
    AMO_DONE
  } amo_state_e;

  ls_state_e             ls_state_q;
  amo_state_e            amo_state_q;
  logic                  first_fetch_q;
  lsu_pkg::word_t        amo_addr_q;
  lsu_pkg::word_t        amo_value_q;

  lsu_pkg::word_t        ld_offset;
  lsu_pkg::word_t        st_offset;
  logic                  is_fetch;
  logic                  is_load;
  logic                  is_store;
  logic                  is_amo;
  logic                  ls_ready;
  logic                  fetch_go;
  logic                  ld_go;
  logic                  st_go;
  logic                  amo_rd_go;
  logic                  amo_wr_go;
  logic                  ls_rsp;
  logic                  fetch_done;
  logic                  ld_done;
  logic                  amo_rd_done;
  logic                  amo_wr_done;

  logic                  req_go;
  lsu_pkg::access_size_e req_size;
  lsu_pkg::word_t        req_addr;
  lsu_pkg::word_t        req_wdata;
  logic                  req_write;

  function automatic lsu_pkg::word_t extend_load(lsu_pkg::lsu_op_e op, lsu_pkg::word_t data);
    case (op)
      lsu_pkg::OP_LB:  return {{(`LSU_XLEN-8){data[7]}}, data[7:0]};
      lsu_pkg::OP_LBU: return {{(`LSU_XLEN-8){1'b0}}, data[7:0]};
      lsu_pkg::OP_LH:  return {{(`LSU_XLEN-16){data[15]}}, data[15:0]};
      lsu_pkg::OP_LHU: return {{(`LSU_XLEN-16){1'b0}}, data[15:0]};
      default:         return data;
    endcase
  endfunction

  // I-type and S-type immediates
  assign ld_offset = {{(`LSU_XLEN-12){i_ir[31]}}, i_ir[31:20]};
  assign st_offset = {{(`LSU_XLEN-12){i_ir[31]}}, i_ir[31:25], i_ir[11:7]};

  assign is_fetch = (i_phase == lsu_pkg::PHASE_FETCH);
  assign is_load  = !is_fetch && (i_op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
                                               lsu_pkg::OP_LBU, lsu_pkg::OP_LHU});
  assign is_store = !is_fetch && (i_op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW});
  assign is_amo   = !is_fetch && (i_op == lsu_pkg::OP_AMOSWAP);

  // The ir_dv cycle is still owned by the finished fetch, the controller moves on after it
  assign ls_ready  = (ls_state_q == LS_READY) && (amo_state_q == AMO_IDLE) && !o_ir_dv;
  assign fetch_go  = ls_ready && is_fetch && (first_fetch_q || i_start_fetch);
  assign ld_go     = ls_ready && is_load;
  assign st_go     = ls_ready && is_store;
  assign amo_rd_go = ls_ready && is_amo;
  assign amo_wr_go = (amo_state_q == AMO_WR_ISSUE);

  assign ls_rsp           = (ls_state_q == LS_WAITING) && i_bus_rsp;
  assign fetch_done       = ls_rsp && is_fetch;
  assign ld_done          = ls_rsp && is_load;
  assign o_ld_st_finished = ls_rsp && (is_load || is_store);
  assign amo_rd_done      = (amo_state_q == AMO_RD_WAIT) && i_bus_rsp;
  assign amo_wr_done      = (amo_state_q == AMO_WR_WAIT) && i_bus_rsp;

  // Next bus request
  always_comb begin
    req_go    = fetch_go || ld_go || st_go || amo_rd_go || amo_wr_go;
    req_size  = lsu_pkg::SIZE_WORD;
    req_addr  = i_pc;
    req_wdata = i_rs2;
    req_write = 1'b0;
    if (ld_go) begin
      req_addr = i_rs1 + ld_offset;
      if (i_op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LBU}) begin
        req_size = lsu_pkg::SIZE_BYTE;
      end else if (i_op inside {lsu_pkg::OP_LH, lsu_pkg::OP_LHU}) begin
        req_size = lsu_pkg::SIZE_HALF;
      end
    end else if (st_go) begin
      req_addr  = i_rs1 + st_offset;
      req_write = 1'b1;
      if (i_op == lsu_pkg::OP_SB) begin
        req_size  = lsu_pkg::SIZE_BYTE;
        req_wdata = {{(`LSU_XLEN-8){1'b0}}, i_rs2[7:0]};
      end else if (i_op == lsu_pkg::OP_SH) begin
        req_size  = lsu_pkg::SIZE_HALF;
        req_wdata = {{(`LSU_XLEN-16){1'b0}}, i_rs2[15:0]};
      end
    end else if (amo_rd_go) begin
      req_addr = i_rs1;
    end else if (amo_wr_go) begin
      req_addr  = amo_addr_q;
      req_wdata = amo_value_q;
      req_write = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ls_state_q        <= LS_READY;
      amo_state_q       <= AMO_IDLE;
      first_fetch_q     <= 1'b1;
      o_bus_req         <= 1'b0;
      o_ir_dv           <= 1'b0;
      o_loaded_value_dv <= 1'b0;
      o_amo_finished    <= 1'b0;
    end else begin
      o_bus_req         <= req_go;
      o_ir_dv           <= fetch_done;
      o_loaded_value_dv <= ld_done || amo_rd_done;
      o_amo_finished    <= amo_wr_done;

      if (fetch_go) begin
        first_fetch_q <= 1'b0;
      end

      if (fetch_go || ld_go || st_go) begin
        ls_state_q <= LS_WAITING;
      end else if (ls_rsp) begin
        ls_state_q <= LS_READY;
      end

      // Swap sequence, one extra cycle at the end so a held op is not restarted
      case (amo_state_q)
        AMO_IDLE:     if (amo_rd_go) amo_state_q <= AMO_RD_WAIT;
        AMO_RD_WAIT:  if (i_bus_rsp) amo_state_q <= AMO_WR_ISSUE;
        AMO_WR_ISSUE: amo_state_q <= AMO_WR_WAIT;
        AMO_WR_WAIT:  if (i_bus_rsp) amo_state_q <= AMO_DONE;
        default:      amo_state_q <= AMO_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_go) begin
      o_bus_size    <= req_size;
      o_bus_address <= req_addr;
      o_bus_wdata   <= req_wdata;
      o_bus_write   <= req_write;
    end
    if (amo_rd_go) begin
      amo_addr_q  <= i_rs1;
      amo_value_q <= i_rs2;
    end
    if (fetch_done) begin
      o_ir_value <= i_bus_rdata;
    end
    if (ld_done) begin
      o_loaded_value <= extend_load(i_op, i_bus_rdata);
    end else if (amo_rd_done) begin
      o_loaded_value <= i_bus_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_subsystem (
  input  wire                          i_clk,
  input  wire                          i_reset,
  input  wire lsu_pkg::phase_e         i_phase,
  input  wire lsu_pkg::lsu_op_e        i_op,
  input  wire lsu_pkg::word_t          i_rs1,
  input  wire lsu_pkg::word_t          i_rs2,
  input  wire lsu_pkg::word_t          i_ir,
  input  wire lsu_pkg::word_t          i_pc,
  input  wire                          i_start_fetch,
  output lsu_pkg::word_t               o_ir_value,
  output logic                         o_ir_dv,
  output lsu_pkg::word_t               o_loaded_value,
  output logic                         o_loaded_value_dv,
  output logic                         o_ld_st_finished,
  output logic                         o_amo_finished
);

  // Unit to memory link
  logic                  bus_req;
  lsu_pkg::access_size_e bus_size;
  lsu_pkg::word_t        bus_address;
  lsu_pkg::word_t        bus_wdata;
  logic                  bus_write;
  logic                  bus_rsp;
  lsu_pkg::word_t        bus_rdata;

  load_store u_load_store (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_phase           (i_phase),
    .i_op              (i_op),
    .i_rs1             (i_rs1),
    .i_rs2             (i_rs2),
    .i_ir              (i_ir),
    .i_pc              (i_pc),
    .i_start_fetch     (i_start_fetch),
    .i_bus_rsp         (bus_rsp),
    .i_bus_rdata       (bus_rdata),
    .o_bus_req         (bus_req),
    .o_bus_size        (bus_size),
    .o_bus_address     (bus_address),
    .o_bus_wdata       (bus_wdata),
    .o_bus_write       (bus_write),
    .o_ir_value        (o_ir_value),
    .o_ir_dv           (o_ir_dv),
    .o_loaded_value    (o_loaded_value),
    .o_loaded_value_dv (o_loaded_value_dv),
    .o_ld_st_finished  (o_ld_st_finished),
    .o_amo_finished    (o_amo_finished)
  );

  data_memory #(
    .MEM_WORDS (`LSU_MEM_WORDS),
    .MEM_WAIT  (`LSU_MEM_WAIT)
  ) u_data_memory (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_req     (bus_req),
    .i_size    (bus_size),
    .i_address (bus_address),
    .i_wdata   (bus_wdata),
    .i_write   (bus_write),
    .o_rsp     (bus_rsp),
    .o_rdata   (bus_rdata)
  );

endmodule

`default_nettype wire

// ==== verification/lsu_subsystem_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem_sva (
  input wire i_clk,
  input wire i_reset,
  input wire i_bus_req,
  input wire i_bus_rsp,
  input wire i_ir_dv,
  input wire i_loaded_value_dv,
  input wire i_ld_st_finished,
  input wire i_amo_finished
);

  logic rsp_pending;

  // Outstanding request, cleared by its response
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rsp_pending <= 1'b0;
    end else if (i_bus_req) begin
      rsp_pending <= 1'b1;
    end else if (i_bus_rsp) begin
      rsp_pending <= 1'b0;
    end
  end

  req_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
    i_bus_req |=> !i_bus_req)
    else $error("bus request high for two cycles in a row");

  req_after_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
    i_bus_req |-> !rsp_pending)
    else $error("bus request issued before the previous response");

  dv_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_ir_dv && i_loaded_value_dv))
    else $error("fetch and load data valid high together");

  strobes_low_after_reset: assert property (@(posedge i_clk)
    i_reset |=> !(i_bus_req || i_ir_dv || i_loaded_value_dv || i_ld_st_finished ||
                  i_amo_finished))
    else $error("strobe high in the cycle after reset");

endmodule

bind load_store lsu_subsystem_sva u_lsu_sva (
  .i_clk             (i_clk),
  .i_reset           (i_reset),
  .i_bus_req         (o_bus_req),
  .i_bus_rsp         (i_bus_rsp),
  .i_ir_dv           (o_ir_dv),
  .i_loaded_value_dv (o_loaded_value_dv),
  .i_ld_st_finished  (o_ld_st_finished),
  .i_amo_finished    (o_amo_finished)
);

`default_nettype wire

// ==== verification/lsu_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_subsystem_tb;

  localparam int MAX_PATTERNS   = 64;
  localparam int PATTERN_CYCLES = 2 * `LSU_MEM_WAIT + 8;
  localparam int STALL_CYCLES   = `LSU_MEM_WAIT + 4;

  typedef enum int {KIND_FETCH, KIND_LOAD, KIND_STORE, KIND_AMO, KIND_NONE} kind_e;

  logic             i_clk;
  logic             i_reset;
  lsu_pkg::phase_e  i_phase;
  lsu_pkg::lsu_op_e i_op;
  lsu_pkg::word_t   i_rs1;
  lsu_pkg::word_t   i_rs2;
  lsu_pkg::word_t   i_ir;
  lsu_pkg::word_t   i_pc;
  logic             i_start_fetch;
  lsu_pkg::word_t   o_ir_value;
  logic             o_ir_dv;
  lsu_pkg::word_t   o_loaded_value;
  logic             o_loaded_value_dv;
  logic             o_ld_st_finished;
  logic             o_amo_finished;

  lsu_pkg::phase_e  pat_phase  [MAX_PATTERNS];
  lsu_pkg::lsu_op_e pat_op     [MAX_PATTERNS];
  lsu_pkg::word_t   pat_rs1    [MAX_PATTERNS];
  lsu_pkg::word_t   pat_rs2    [MAX_PATTERNS];
  lsu_pkg::word_t   pat_ir     [MAX_PATTERNS];
  lsu_pkg::word_t   pat_pc     [MAX_PATTERNS];
  logic             pat_start  [MAX_PATTERNS];
  lsu_pkg::word_t   pat_expect [MAX_PATTERNS];
  int               n_patterns = 0;
  int               cycle_count = 0;
  int               timeout_limit = 0;
  logic             first_fetch_seen = 1'b0;
  logic             seen_ir;
  logic             seen_ldv;
  logic             seen_ldst;
  logic             seen_amo;

  lsu_subsystem uut (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_phase           (i_phase),
    .i_op              (i_op),
    .i_rs1             (i_rs1),
    .i_rs2             (i_rs2),
    .i_ir              (i_ir),
    .i_pc              (i_pc),
    .i_start_fetch     (i_start_fetch),
    .o_ir_value        (o_ir_value),
    .o_ir_dv           (o_ir_dv),
    .o_loaded_value    (o_loaded_value),
    .o_loaded_value_dv (o_loaded_value_dv),
    .o_ld_st_finished  (o_ld_st_finished),
    .o_amo_finished    (o_amo_finished)
  );

  always #20 i_clk = ~i_clk;

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input lsu_pkg::word_t exp,
                            input lsu_pkg::word_t got);
    if (got !== exp) begin
      $display("FAILED %s exp=%h got=%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_done(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("FAILED %s exp=%h got=%h", name, exp, got);
      abort_run();
    end
  endtask

  // Whole-run limit sized from the number of patterns
  always @(posedge i_clk) begin
    if (!i_reset && timeout_limit > 0) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
        $display("timeout after %0d cycles without finishing the patterns", cycle_count);
        abort_run();
      end
    end
  end

  task automatic read_patterns();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_phase;
    logic [31:0] f_op;
    logic [31:0] f_rs1;
    logic [31:0] f_rs2;
    logic [31:0] f_ir;
    logic [31:0] f_pc;
    logic [31:0] f_start;
    logic [31:0] f_exp;
    fd = $fopen("verification/lsu_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/lsu_patterns.txt");
      abort_run();
    end
    while (n_patterns < MAX_PATTERNS && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                       f_phase, f_op, f_rs1, f_rs2, f_ir, f_pc, f_start, f_exp);
      if (fields != 8) begin
        $display("malformed pattern line %s", line);
        abort_run();
      end
      pat_phase[n_patterns]  = lsu_pkg::phase_e'(f_phase[0]);
      pat_op[n_patterns]     = lsu_pkg::lsu_op_e'(f_op[`LSU_OP_W-1:0]);
      pat_rs1[n_patterns]    = f_rs1;
      pat_rs2[n_patterns]    = f_rs2;
      pat_ir[n_patterns]     = f_ir;
      pat_pc[n_patterns]     = f_pc;
      pat_start[n_patterns]  = f_start[0];
      pat_expect[n_patterns] = f_exp;
      n_patterns++;
    end
    $fclose(fd);
  endtask

  function automatic kind_e kind_of(input int idx);
    if (pat_phase[idx] == lsu_pkg::PHASE_FETCH) begin
      return KIND_FETCH;
    end
    case (pat_op[idx])
      lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
      lsu_pkg::OP_LBU, lsu_pkg::OP_LHU: return KIND_LOAD;
      lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW: return KIND_STORE;
      lsu_pkg::OP_AMOSWAP: return KIND_AMO;
      default: return KIND_NONE;
    endcase
  endfunction

  task automatic apply_pattern(input int idx);
    i_phase       <= pat_phase[idx];
    i_op          <= pat_op[idx];
    i_rs1         <= pat_rs1[idx];
    i_rs2         <= pat_rs2[idx];
    i_ir          <= pat_ir[idx];
    i_pc          <= pat_pc[idx];
    i_start_fetch <= pat_start[idx];
  endtask

  task automatic apply_idle();
    i_phase       <= lsu_pkg::PHASE_EXECUTE;
    i_op          <= lsu_pkg::lsu_op_e'(0);
    i_start_fetch <= 1'b0;
  endtask

  // Each strobe may pulse once, and only for the operation that owns it
  task automatic monitor_cycle(input kind_e kind, input int idx);
    if (kind != KIND_FETCH || seen_ir) begin
      check_done("o_ir_dv", 1'b0, o_ir_dv);
    end
    if ((kind != KIND_LOAD && kind != KIND_AMO) || seen_ldv) begin
      check_done("o_loaded_value_dv", 1'b0, o_loaded_value_dv);
    end
    if ((kind != KIND_LOAD && kind != KIND_STORE) || seen_ldst) begin
      check_done("o_ld_st_finished", 1'b0, o_ld_st_finished);
    end
    if (kind != KIND_AMO || seen_amo) begin
      check_done("o_amo_finished", 1'b0, o_amo_finished);
    end
    if (o_ir_dv) begin
      check_word("o_ir_value", pat_expect[idx], o_ir_value);
      seen_ir = 1'b1;
    end
    if (o_loaded_value_dv) begin
      check_word("o_loaded_value", pat_expect[idx], o_loaded_value);
      seen_ldv = 1'b1;
    end
    seen_ldst = seen_ldst | o_ld_st_finished;
    seen_amo  = seen_amo | o_amo_finished;
  endtask

  task automatic run_pattern(input int idx);
    kind_e kind;
    int    waited;
    logic  done;
    kind      = kind_of(idx);
    waited    = 0;
    done      = 1'b0;
    seen_ir   = 1'b0;
    seen_ldv  = 1'b0;
    seen_ldst = 1'b0;
    seen_amo  = 1'b0;
    if (kind == KIND_NONE) begin
      $display("pattern %0d holds no memory operation", idx);
      abort_run();
    end
    // Later fetches must wait for start_fetch
    if (kind == KIND_FETCH && !pat_start[idx] && first_fetch_seen) begin
      repeat (STALL_CYCLES) begin
        @(negedge i_clk);
        monitor_cycle(KIND_NONE, idx);
      end
      @(posedge i_clk);
      i_start_fetch <= 1'b1;
    end
    while (!done) begin
      @(negedge i_clk);
      monitor_cycle(kind, idx);
      waited++;
      done = (kind == KIND_FETCH) ? seen_ir : (kind == KIND_AMO) ? seen_amo : seen_ldst;
      if (!done && waited >= PATTERN_CYCLES) begin
        $display("no completion strobe for pattern %0d within %0d cycles", idx, waited);
        abort_run();
      end
    end
    if (kind == KIND_FETCH) begin
      first_fetch_seen = 1'b1;
    end
    @(posedge i_clk);
    if (idx + 1 < n_patterns) begin
      apply_pattern(idx + 1);
    end else begin
      apply_idle();
    end
    // Load data arrives on the edge after the response
    if (kind == KIND_LOAD) begin
      @(negedge i_clk);
      monitor_cycle(kind, idx);
    end
    if (kind == KIND_LOAD || kind == KIND_AMO) begin
      check_done("o_loaded_value_dv", 1'b1, seen_ldv);
    end
  endtask

  initial begin
    i_clk         = 1'b0;
    i_reset       = 1'b1;
    i_phase       = lsu_pkg::PHASE_EXECUTE;
    i_op          = lsu_pkg::lsu_op_e'(0);
    i_rs1         = '0;
    i_rs2         = '0;
    i_ir          = '0;
    i_pc          = '0;
    i_start_fetch = 1'b0;
    read_patterns();
    timeout_limit = n_patterns * PATTERN_CYCLES;
    repeat (5) @(posedge i_clk);
    i_reset <= 1'b0;
    @(posedge i_clk);
    apply_pattern(0);
    for (int idx = 0; idx < n_patterns; idx++) begin
      run_pattern(idx);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsu_subsystem.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/data_memory.sv
rtl/load_store.sv
rtl/lsu_subsystem.sv
verification/lsu_subsystem_sva.sv
verification/lsu_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module lsu_subsystem_tb \
  -f lsu_subsystem.f \
  -Mdir obj_dir \
  && ./obj_dir/Vlsu_subsystem_tb \
  || { echo "simulation run did not pass"; exit 1; }

// ==== verification/lsu_patterns.txt ====
# Hex columns phase op rs1 rs2 ir pc start_fetch expected
# Phase 0 fetches at pc and phase 1 runs op, expected is the fetched or loaded word
1 22 00000040 00c58513 00000000 00000000 0 00000000
1 22 00000048 12345678 fe000e00 00000000 0 00000000
0 00 00000000 00000000 00000000 00000040 0 00c58513
1 1d 00000048 00000000 ffc00000 00000000 0 12345678
1 1d 0000003c 00000000 00800000 00000000 0 12345678
1 22 00000078 a1b2c3d4 00000400 00000000 0 00000000
1 20 00000081 ffffff5e 00000000 00000000 0 00000000
1 21 00000082 12349c7f 00000000 00000000 0 00000000
1 1d 00000080 00000000 00000000 00000000 0 9c7f5ed4
1 1b 00000081 00000000 00000000 00000000 0 0000005e
1 1b 00000083 00000000 00000000 00000000 0 ffffff9c
1 1e 00000083 00000000 00000000 00000000 0 0000009c
1 1c 00000082 00000000 00000000 00000000 0 ffff9c7f
1 1f 00000082 00000000 00000000 00000000 0 00009c7f
1 1c 00000080 00000000 00000000 00000000 0 00005ed4
1 1e 00000080 00000000 00000000 00000000 0 000000d4
1 3c 00000044 cafef00d 00000000 00000000 0 12345678
1 1d 00000044 00000000 00000000 00000000 0 cafef00d
1 1c 00000046 00000000 00000000 00000000 0 ffffcafe
1 22 00000048 fe010113 00000000 00000000 0 00000000
0 00 00000000 00000000 00000000 00000048 0 fe010113
0 00 00000000 00000000 00000000 00000040 1 00c58513
